// File: Makefile
TOP = or1k_lite_core_tb

sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f or1k_lite_core.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: design/or1k_lite_alu.sv
// OR1K lite ALU and serial shifter
`default_nettype none

module or1k_lite_alu
   import or1k_lite_pkg::*;
   (
   input  wire           clk,
   input  wire           arst_n_i,
   input  wire           start_i,
   input  wire           step_i,
   input  wire decode_t  dec_i,
   input  wire operand_t rfa_data_i,
   input  wire operand_t rfb_data_i,
   output operand_t      result_o
   );

   operand_t opb;
   operand_t alu_res;
   operand_t result_q;

   always_comb begin
      case (dec_i.imm_sel)
         IMM_SEXT: opb = {{16{dec_i.imm16[15]}}, dec_i.imm16};
         IMM_ZEXT: opb = {16'h0000, dec_i.imm16};
         IMM_HIGH: opb = {dec_i.imm16, 16'h0000};
         default:  opb = rfb_data_i;
      endcase
   end

   always_comb begin
      case (dec_i.alu_opc)
         ALU_OPC_ADD:  alu_res = rfa_data_i + opb;
         ALU_OPC_SUB:  alu_res = rfa_data_i - opb;
         ALU_OPC_AND:  alu_res = rfa_data_i & opb;
         ALU_OPC_OR:   alu_res = rfa_data_i | opb;
         ALU_OPC_XOR:  alu_res = rfa_data_i ^ opb;
         // Shift starts from ra and moves a bit per step
         ALU_OPC_SHRT: alu_res = rfa_data_i;
         default:      alu_res = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         result_q <= '0;
      end else if (start_i) begin
         result_q <= alu_res;
      end else if (step_i) begin
         case (dec_i.shift_kind)
            SHIFT_SLL: result_q <= {result_q[30:0], 1'b0};
            SHIFT_SRL: result_q <= {1'b0, result_q[31:1]};
            SHIFT_SRA: result_q <= {result_q[31], result_q[31:1]};
            default:   result_q <= result_q;
         endcase
      end
   end

   assign result_o = result_q;

endmodule

`default_nettype wire

// File: design/or1k_lite_core.sv
// OR1K lite execution slice top
`default_nettype none

module or1k_lite_core
   import or1k_lite_pkg::*;
   #(
   parameter int FEATURE_SRA = 1
   )
   (
   input  wire        clk,
   input  wire        arst_n_i,
   input  wire        insn_valid_i,
   input  wire insn_t insn_i,
   output logic       busy_o,
   output logic       wb_valid_o,
   output rf_adr_t    wb_adr_o,
   output operand_t   wb_data_o,
   output logic       except_illegal_o,
   output logic       except_syscall_o
   );

   decode_t    dec;
   logic       illegal;
   logic       syscall;
   logic       shift_done;
   logic       alu_start;
   logic       alu_step;
   logic       cnt_load;
   logic [4:0] cnt_amount;
   rf_adr_t    rfa_adr;
   rf_adr_t    rfb_adr;
   operand_t   rfa_data;
   operand_t   rfb_data;

   or1k_lite_decode #(
      .FEATURE_SRA (FEATURE_SRA)
   ) or1k_lite_decode_i (
      .insn_i           (insn_i),
      .dec_o            (dec),
      .except_illegal_o (illegal),
      .except_syscall_o (syscall)
   );

   or1k_lite_seq_fsm or1k_lite_seq_fsm_i (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .insn_valid_i     (insn_valid_i),
      .dec_i            (dec),
      .illegal_i        (illegal),
      .syscall_i        (syscall),
      .shift_done_i     (shift_done),
      .rfb_data_i       (rfb_data),
      .busy_o           (busy_o),
      .alu_start_o      (alu_start),
      .alu_step_o       (alu_step),
      .cnt_load_o       (cnt_load),
      .cnt_amount_o     (cnt_amount),
      .rfa_adr_o        (rfa_adr),
      .rfb_adr_o        (rfb_adr),
      .wb_valid_o       (wb_valid_o),
      .wb_adr_o         (wb_adr_o),
      .except_illegal_o (except_illegal_o),
      .except_syscall_o (except_syscall_o)
   );

   or1k_lite_shift_count or1k_lite_shift_count_i (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .load_i   (cnt_load),
      .amount_i (cnt_amount),
      .done_o   (shift_done)
   );

   // The sequencer holds the decode stable while the ALU runs
   or1k_lite_alu or1k_lite_alu_i (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .start_i    (alu_start),
      .step_i     (alu_step),
      .dec_i      (or1k_lite_seq_fsm_i.dec_q),
      .rfa_data_i (rfa_data),
      .rfb_data_i (rfb_data),
      .result_o   (wb_data_o)
   );

   or1k_lite_regfile or1k_lite_regfile_i (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .rfa_adr_i  (rfa_adr),
      .rfb_adr_i  (rfb_adr),
      .we_i       (wb_valid_o),
      .wd_adr_i   (wb_adr_o),
      .wd_data_i  (wb_data_o),
      .rfa_data_o (rfa_data),
      .rfb_data_o (rfb_data)
   );

endmodule

`default_nettype wire

// File: design/or1k_lite_decode.sv
// OR1K lite instruction decoder
`default_nettype none

module or1k_lite_decode
   import or1k_lite_pkg::*;
   #(
   parameter int FEATURE_SRA = 1
   )
   (
   input  wire insn_t insn_i,
   output decode_t    dec_o,
   output logic       except_illegal_o,
   output logic       except_syscall_o
   );

   logic [5:0]  opc_insn;
   alu_opc_t    opc_alu;
   shift_kind_t shrt_kind;
   logic        op_movhi;
   logic        op_shift;
   logic        shrt_illegal;

   assign opc_insn  = insn_i[31:26];
   assign opc_alu   = insn_i[3:0];
   assign shrt_kind = insn_i[7:6];
   assign op_movhi  = (opc_insn == OPC_MOVHI);
   assign op_shift  = (opc_insn == OPC_ALU && opc_alu == ALU_OPC_SHRT) ||
                      (opc_insn == OPC_SHRTI);

   assign except_syscall_o = (opc_insn == OPC_SYS) && (insn_i[25:16] == SYS_SYSCALL);

   always_comb begin
      // Immediate logic ops reuse the register-form ALU codes
      case (opc_insn)
         OPC_ANDI:            dec_o.alu_opc = ALU_OPC_AND;
         OPC_ORI:             dec_o.alu_opc = ALU_OPC_OR;
         OPC_XORI:            dec_o.alu_opc = ALU_OPC_XOR;
         OPC_ADDI, OPC_MOVHI: dec_o.alu_opc = ALU_OPC_ADD;
         OPC_SHRTI:           dec_o.alu_opc = ALU_OPC_SHRT;
         default:             dec_o.alu_opc = opc_alu;
      endcase

      // Shift immediates also take the zero-extended form, amount in bits 4:0
      case (opc_insn)
         OPC_ADDI:                                dec_o.imm_sel = IMM_SEXT;
         OPC_ANDI, OPC_ORI, OPC_XORI, OPC_SHRTI:  dec_o.imm_sel = IMM_ZEXT;
         OPC_MOVHI:                               dec_o.imm_sel = IMM_HIGH;
         default:                                 dec_o.imm_sel = IMM_NONE;
      endcase

      dec_o.shift_kind = shrt_kind;
      dec_o.is_shift   = op_shift;
      dec_o.imm16      = insn_i[15:0];
      dec_o.rfd_adr    = insn_i[25:21];
      // movhi adds its immediate to r0
      dec_o.rfa_adr    = op_movhi ? '0 : insn_i[20:16];
      dec_o.rfb_adr    = insn_i[15:11];
      dec_o.rf_wb      = !except_illegal_o && !except_syscall_o;
   end

   always_comb begin
      case (shrt_kind)
         SHIFT_SLL, SHIFT_SRL: shrt_illegal = 1'b0;
         SHIFT_SRA:            shrt_illegal = (FEATURE_SRA == 0);
         default:              shrt_illegal = 1'b1;
      endcase
   end

   // Anything outside the supported subset traps as illegal
   always_comb begin
      case (opc_insn)
         OPC_ADDI,
         OPC_ANDI,
         OPC_ORI,
         OPC_XORI: begin
            except_illegal_o = 1'b0;
         end
         OPC_MOVHI: begin
            // Bit 16 set is l.macrc
            except_illegal_o = insn_i[16];
         end
         OPC_SHRTI: begin
            except_illegal_o = shrt_illegal;
         end
         OPC_ALU: begin
            case (opc_alu)
               ALU_OPC_ADD,
               ALU_OPC_SUB,
               ALU_OPC_AND,
               ALU_OPC_OR,
               ALU_OPC_XOR:  except_illegal_o = 1'b0;
               ALU_OPC_SHRT: except_illegal_o = shrt_illegal;
               default:      except_illegal_o = 1'b1;
            endcase
         end
         OPC_SYS: begin
            // Trap and the sync forms are not kept
            except_illegal_o = !except_syscall_o;
         end
         default: begin
            except_illegal_o = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: design/or1k_lite_pkg.sv
// OR1K lite execution slice
// Shared types and encodings
`default_nettype none

package or1k_lite_pkg;

   typedef logic [31:0] insn_t;
   typedef logic [31:0] operand_t;
   typedef logic [4:0]  rf_adr_t;
   typedef logic [3:0]  alu_opc_t;
   typedef logic [1:0]  shift_kind_t;

   // Major opcodes in insn[31:26]
   localparam logic [5:0] OPC_MOVHI = 6'h06;
   localparam logic [5:0] OPC_SYS   = 6'h08;
   localparam logic [5:0] OPC_ADDI  = 6'h27;
   localparam logic [5:0] OPC_ANDI  = 6'h29;
   localparam logic [5:0] OPC_ORI   = 6'h2a;
   localparam logic [5:0] OPC_XORI  = 6'h2b;
   localparam logic [5:0] OPC_SHRTI = 6'h2e;
   localparam logic [5:0] OPC_ALU   = 6'h38;

   // l.sys when insn[25:16] holds this value
   localparam logic [9:0] SYS_SYSCALL = 10'h000;

   // ALU opcode field, insn[3:0]
   localparam alu_opc_t ALU_OPC_ADD  = 4'h0;
   localparam alu_opc_t ALU_OPC_SUB  = 4'h2;
   localparam alu_opc_t ALU_OPC_AND  = 4'h3;
   localparam alu_opc_t ALU_OPC_OR   = 4'h4;
   localparam alu_opc_t ALU_OPC_XOR  = 4'h5;
   localparam alu_opc_t ALU_OPC_SHRT = 4'h8;

   // Shift type, insn[7:6]
   localparam shift_kind_t SHIFT_SLL = 2'd0;
   localparam shift_kind_t SHIFT_SRL = 2'd1;
   localparam shift_kind_t SHIFT_SRA = 2'd2;

   typedef enum logic [1:0] {
      IMM_NONE,
      IMM_SEXT,
      IMM_ZEXT,
      IMM_HIGH
   } imm_sel_t;

   typedef struct packed {
      alu_opc_t    alu_opc;
      shift_kind_t shift_kind;
      logic        is_shift;
      imm_sel_t    imm_sel;
      logic [15:0] imm16;
      rf_adr_t     rfd_adr;
      rf_adr_t     rfa_adr;
      rf_adr_t     rfb_adr;
      logic        rf_wb;
   } decode_t;

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_EXEC,
      SEQ_SHIFT,
      SEQ_RETIRE
   } seq_state_t;

endpackage

`default_nettype wire

// File: design/or1k_lite_regfile.sv
// OR1K lite register file
`default_nettype none

module or1k_lite_regfile
   import or1k_lite_pkg::*;
   (
   input  wire           clk,
   input  wire           arst_n_i,
   input  wire rf_adr_t  rfa_adr_i,
   input  wire rf_adr_t  rfb_adr_i,
   input  wire           we_i,
   input  wire rf_adr_t  wd_adr_i,
   input  wire operand_t wd_data_i,
   output operand_t      rfa_data_o,
   output operand_t      rfb_data_o
   );

   operand_t regs [32];

   // r0 is never written, so it keeps its reset zero
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && (wd_adr_i != '0)) begin
         regs[wd_adr_i] <= wd_data_i;
      end
   end

   assign rfa_data_o = regs[rfa_adr_i];
   assign rfb_data_o = regs[rfb_adr_i];

   wr_adr_known: assert property (@(posedge clk) disable iff (!arst_n_i)
      we_i |-> !$isunknown(wd_adr_i));

endmodule

`default_nettype wire

// File: design/or1k_lite_seq_fsm.sv
// OR1K lite instruction sequencer
`default_nettype none

module or1k_lite_seq_fsm
   import or1k_lite_pkg::*;
   (
   input  wire           clk,
   input  wire           arst_n_i,
   input  wire           insn_valid_i,
   input  wire decode_t  dec_i,
   input  wire           illegal_i,
   input  wire           syscall_i,
   input  wire           shift_done_i,
   input  wire operand_t rfb_data_i,
   output logic          busy_o,
   output logic          alu_start_o,
   output logic          alu_step_o,
   output logic          cnt_load_o,
   output logic [4:0]    cnt_amount_o,
   output rf_adr_t       rfa_adr_o,
   output rf_adr_t       rfb_adr_o,
   output logic          wb_valid_o,
   output rf_adr_t       wb_adr_o,
   output logic          except_illegal_o,
   output logic          except_syscall_o
   );

   seq_state_t state_q;
   seq_state_t state_d;
   decode_t    dec_q;
   logic       accept;
   logic       go;
   logic [4:0] shamt;

   assign accept = (state_q == SEQ_IDLE) && insn_valid_i;
   assign go     = accept && !illegal_i && !syscall_i;

   // Register forms take the amount from rb, immediate forms from imm16
   assign shamt = !dec_q.is_shift       ? 5'd0 :
                  (dec_q.imm_sel == IMM_NONE) ? rfb_data_i[4:0] : dec_q.imm16[4:0];

   always_comb begin
      state_d = state_q;
      case (state_q)
         SEQ_IDLE:  if (go) state_d = SEQ_EXEC;
         SEQ_EXEC:  state_d = (shamt != '0) ? SEQ_SHIFT : SEQ_RETIRE;
         SEQ_SHIFT: if (shift_done_i) state_d = SEQ_RETIRE;
         default:   state_d = SEQ_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q          <= SEQ_IDLE;
         except_illegal_o <= 1'b0;
         except_syscall_o <= 1'b0;
      end else begin
         state_q          <= state_d;
         except_illegal_o <= accept && illegal_i;
         except_syscall_o <= accept && syscall_i && !illegal_i;
      end
   end

   always_ff @(posedge clk) begin
      if (go) begin
         dec_q <= dec_i;
      end
   end

   assign busy_o      = (state_q != SEQ_IDLE);
   assign alu_start_o = (state_q == SEQ_EXEC);
   assign alu_step_o  = (state_q == SEQ_SHIFT);
   assign cnt_load_o  = alu_start_o && (shamt != '0);
   // Counter holds the steps left after the current one
   assign cnt_amount_o = shamt - 5'd1;
   assign rfa_adr_o   = dec_q.rfa_adr;
   assign rfb_adr_o   = dec_q.rfb_adr;
   assign wb_valid_o  = (state_q == SEQ_RETIRE) && dec_q.rf_wb;
   assign wb_adr_o    = dec_q.rfd_adr;

   // Done follows the loaded amount one cycle later
   shift_done_timing: assert property (@(posedge clk) disable iff (!arst_n_i)
      cnt_load_o |=> (shift_done_i == ($past(cnt_amount_o) == 5'd0)));

endmodule

`default_nettype wire

// File: design/or1k_lite_shift_count.sv
// OR1K lite shift step counter
`default_nettype none

module or1k_lite_shift_count (
   input  wire       clk,
   input  wire       arst_n_i,
   input  wire       load_i,
   input  wire [4:0] amount_i,
   output logic      done_o
   );

   logic [4:0] count_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q <= '0;
      end else if (load_i) begin
         count_q <= amount_i;
      end else if (count_q != '0) begin
         count_q <= count_q - 5'd1;
      end
   end

   assign done_o = (count_q == '0);

   // A new shift only begins once the last one has run out
   load_when_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
      load_i |-> (count_q == '0));

endmodule

`default_nettype wire

// File: or1k_lite_core.f
design/or1k_lite_pkg.sv
design/or1k_lite_decode.sv
design/or1k_lite_regfile.sv
design/or1k_lite_alu.sv
design/or1k_lite_shift_count.sv
design/or1k_lite_seq_fsm.sv
design/or1k_lite_core.sv
tests/or1k_lite_core_tb.sv

// File: tests/or1k_lite_core_tb.sv
// OR1K lite execution slice testbench
`default_nettype none

module or1k_lite_core_tb
   import or1k_lite_pkg::*;
   ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT = 64;

   typedef enum logic [4:0] {
      K_MOVHI, K_ORI, K_ADDI, K_ANDI, K_XORI,
      K_ADD, K_SUB, K_AND, K_OR, K_XOR,
      K_SLL, K_SRL, K_SRA, K_SLLI, K_SRLI, K_SRAI,
      K_LOAD, K_MUL, K_SYS
   } kind_t;

   typedef struct packed {
      kind_t       kind;
      rf_adr_t     rd;
      rf_adr_t     ra;
      rf_adr_t     rb;
      logic [15:0] imm;
      logic        rnd;
   } row_t;

   logic     clk;
   logic     arst_n_i;
   logic     insn_valid_i;
   insn_t    insn_i;
   logic     busy_o;
   logic     wb_valid_o;
   rf_adr_t  wb_adr_o;
   operand_t wb_data_o;
   logic     except_illegal_o;
   logic     except_syscall_o;

   operand_t    regs [32];
   row_t        rows [$];
   logic [31:0] lfsr_q;

   or1k_lite_core #(
      .FEATURE_SRA (1)
   ) or1k_lite_core_i (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .insn_valid_i     (insn_valid_i),
      .insn_i           (insn_i),
      .busy_o           (busy_o),
      .wb_valid_o       (wb_valid_o),
      .wb_adr_o         (wb_adr_o),
      .wb_data_o        (wb_data_o),
      .except_illegal_o (except_illegal_o),
      .except_syscall_o (except_syscall_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Fail %s: got %h expected %h", name, got, exp);
      abort_run();
   endtask

   task automatic report_problem(input string what);
      $display("Error: %s", what);
      abort_run();
   endtask

   // Galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] next_lfsr(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [15:0] random_half();
      logic [15:0] v;
      for (int i = 0; i < 16; i++) begin
         v[i]   = lfsr_q[0];
         lfsr_q = next_lfsr(lfsr_q);
      end
      return v;
   endfunction

   function automatic void add_row(input kind_t k, input int rd, input int ra, input int rb,
                                   input logic [15:0] imm, input logic rnd);
      rows.push_back(row_t'{k, 5'(rd), 5'(ra), 5'(rb), imm, rnd});
   endfunction

   // Instruction words in the architectural field layout
   function automatic insn_t build_insn(input kind_t k, input rf_adr_t rd, input rf_adr_t ra,
                                        input rf_adr_t rb, input logic [15:0] imm);
      case (k)
         K_MOVHI: return {OPC_MOVHI, rd, 5'd0, imm};
         K_ORI:   return {OPC_ORI, rd, ra, imm};
         K_ADDI:  return {OPC_ADDI, rd, ra, imm};
         K_ANDI:  return {OPC_ANDI, rd, ra, imm};
         K_XORI:  return {OPC_XORI, rd, ra, imm};
         K_ADD:   return {OPC_ALU, rd, ra, rb, 3'b000, 2'b00, 2'b00, ALU_OPC_ADD};
         K_SUB:   return {OPC_ALU, rd, ra, rb, 3'b000, 2'b00, 2'b00, ALU_OPC_SUB};
         K_AND:   return {OPC_ALU, rd, ra, rb, 3'b000, 2'b00, 2'b00, ALU_OPC_AND};
         K_OR:    return {OPC_ALU, rd, ra, rb, 3'b000, 2'b00, 2'b00, ALU_OPC_OR};
         K_XOR:   return {OPC_ALU, rd, ra, rb, 3'b000, 2'b00, 2'b00, ALU_OPC_XOR};
         K_SLL:   return {OPC_ALU, rd, ra, rb, 3'b000, SHIFT_SLL, 2'b00, ALU_OPC_SHRT};
         K_SRL:   return {OPC_ALU, rd, ra, rb, 3'b000, SHIFT_SRL, 2'b00, ALU_OPC_SHRT};
         K_SRA:   return {OPC_ALU, rd, ra, rb, 3'b000, SHIFT_SRA, 2'b00, ALU_OPC_SHRT};
         K_SLLI:  return {OPC_SHRTI, rd, ra, 8'h00, SHIFT_SLL, 1'b0, imm[4:0]};
         K_SRLI:  return {OPC_SHRTI, rd, ra, 8'h00, SHIFT_SRL, 1'b0, imm[4:0]};
         K_SRAI:  return {OPC_SHRTI, rd, ra, 8'h00, SHIFT_SRA, 1'b0, imm[4:0]};
         // l.lwz and l.mul, both outside the subset
         K_LOAD:  return {6'h21, rd, ra, imm};
         K_MUL:   return {OPC_ALU, rd, ra, rb, 3'b011, 2'b00, 2'b00, 4'h6};
         K_SYS:   return {OPC_SYS, 10'h000, imm};
         default: return '0;
      endcase
   endfunction

   function automatic operand_t model_result(input kind_t k, input operand_t a,
                                             input operand_t b, input logic [15:0] imm,
                                             input logic [4:0] amt);
      operand_t zext;
      operand_t sext;
      zext = {16'h0000, imm};
      sext = {{16{imm[15]}}, imm};
      case (k)
         K_MOVHI:       return {imm, 16'h0000};
         K_ORI:         return a | zext;
         K_ADDI:        return a + sext;
         K_ANDI:        return a & zext;
         K_XORI:        return a ^ zext;
         K_ADD:         return a + b;
         K_SUB:         return a - b;
         K_AND:         return a & b;
         K_OR:          return a | b;
         K_XOR:         return a ^ b;
         K_SLL, K_SLLI: return a << amt;
         K_SRL, K_SRLI: return a >> amt;
         K_SRA, K_SRAI: return operand_t'($signed(a) >>> amt);
         default:       return '0;
      endcase
   endfunction

   task automatic run_row(input row_t r);
      insn_t       w;
      operand_t    a;
      operand_t    b;
      operand_t    exp_v;
      logic [15:0] imm;
      logic [4:0]  amt;
      int          lat;
      int          cycles;
      logic        exp_ill;
      logic        exp_sys;
      if (r.rnd) begin
         imm = random_half();
      end else begin
         imm = r.imm;
      end
      w = build_insn(r.kind, r.rd, r.ra, r.rb, imm);
      a = (r.kind == K_MOVHI) ? '0 : regs[r.ra];
      b = regs[r.rb];
      if (r.kind inside {K_SLL, K_SRL, K_SRA}) begin
         amt = b[4:0];
      end else if (r.kind inside {K_SLLI, K_SRLI, K_SRAI}) begin
         amt = imm[4:0];
      end else begin
         amt = '0;
      end
      exp_v   = model_result(r.kind, a, b, imm, amt);
      lat     = 2 + int'(amt);
      exp_ill = r.kind inside {K_LOAD, K_MUL};
      exp_sys = (r.kind == K_SYS);

      @(posedge clk);
      insn_i       <= w;
      insn_valid_i <= 1'b1;
      // Acceptance edge
      @(posedge clk);
      insn_valid_i <= 1'b0;
      cycles = 0;

      if (exp_ill || exp_sys) begin
         do begin
            @(negedge clk);
            cycles++;
         end while (!except_illegal_o && !except_syscall_o && cycles < TIMEOUT);
         if (!except_illegal_o && !except_syscall_o) begin
            report_problem("timeout waiting for an exception pulse");
         end
         assert (cycles == 1) else report_problem("exception pulse late after acceptance");
         assert (except_illegal_o == exp_ill)
            else report_mismatch("except_illegal_o", 32'(except_illegal_o), 32'(exp_ill));
         assert (except_syscall_o == exp_sys)
            else report_mismatch("except_syscall_o", 32'(except_syscall_o), 32'(exp_sys));
         assert (!wb_valid_o && !busy_o) else report_problem("writeback or busy on an exception");
         @(negedge clk);
         assert (!except_illegal_o && !except_syscall_o)
            else report_problem("exception pulse longer than one cycle");
      end else begin
         do begin
            @(negedge clk);
            cycles++;
            assert (busy_o) else report_mismatch("busy_o", 32'(busy_o), 32'd1);
            assert (!except_illegal_o && !except_syscall_o)
               else report_problem("exception pulse on a legal instruction");
         end while (!wb_valid_o && cycles < TIMEOUT);
         if (!wb_valid_o) begin
            report_problem("timeout waiting for wb_valid_o");
         end
         assert (cycles == lat)
            else report_problem($sformatf("writeback after %0d cycles, not %0d", cycles, lat));
         assert (wb_adr_o == r.rd) else report_mismatch("wb_adr_o", 32'(wb_adr_o), 32'(r.rd));
         assert (wb_data_o == exp_v) else report_mismatch("wb_data_o", wb_data_o, exp_v);
         // r0 stays zero in the model too
         if (r.rd != '0) begin
            regs[r.rd] = exp_v;
         end
         @(negedge clk);
         assert (!wb_valid_o) else report_mismatch("wb_valid_o", 32'(wb_valid_o), 32'd0);
         assert (!busy_o) else report_mismatch("busy_o", 32'(busy_o), 32'd0);
      end
   endtask

   initial begin
      insn_valid_i = 1'b0;
      insn_i       = '0;
      arst_n_i     = 1'b0;
      lfsr_q       = 32'h31cf_7e17;
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end

      // Every register reads zero after reset
      for (int i = 0; i < 32; i++) begin
         add_row(K_OR, i, i, 0, 16'h0000, 1'b0);
      end
      add_row(K_MOVHI, 1, 0, 0, 16'h0000, 1'b1);
      add_row(K_ORI, 1, 1, 0, 16'h0000, 1'b1);
      add_row(K_MOVHI, 2, 0, 0, 16'h0000, 1'b1);
      add_row(K_ORI, 2, 2, 0, 16'h0000, 1'b1);
      // Negative value for the sign fill of sra
      add_row(K_MOVHI, 10, 0, 0, 16'h8f0f, 1'b0);
      add_row(K_ORI, 10, 10, 0, 16'h1234, 1'b0);
      add_row(K_ADD, 4, 1, 2, 16'h0000, 1'b0);
      add_row(K_SUB, 5, 1, 2, 16'h0000, 1'b0);
      add_row(K_AND, 6, 1, 10, 16'h0000, 1'b0);
      add_row(K_OR, 7, 2, 10, 16'h0000, 1'b0);
      add_row(K_XOR, 8, 1, 2, 16'h0000, 1'b0);
      add_row(K_ADDI, 9, 1, 0, 16'h8001, 1'b0);
      add_row(K_ANDI, 11, 2, 0, 16'hf0f0, 1'b0);
      add_row(K_XORI, 12, 10, 0, 16'ha5a5, 1'b0);
      // Shift amounts, r23 has zero in bits 4:0
      add_row(K_ORI, 20, 0, 0, 16'h0011, 1'b0);
      add_row(K_ORI, 21, 0, 0, 16'h0001, 1'b0);
      add_row(K_ORI, 22, 0, 0, 16'h001f, 1'b0);
      add_row(K_ORI, 23, 0, 0, 16'h0040, 1'b0);
      add_row(K_SLL, 13, 1, 21, 16'h0000, 1'b0);
      add_row(K_SRL, 14, 10, 20, 16'h0000, 1'b0);
      add_row(K_SRA, 15, 10, 22, 16'h0000, 1'b0);
      add_row(K_SRA, 16, 10, 23, 16'h0000, 1'b0);
      add_row(K_SLLI, 17, 2, 0, 16'h0011, 1'b0);
      add_row(K_SRLI, 18, 10, 0, 16'h0000, 1'b0);
      add_row(K_SRAI, 19, 10, 0, 16'h0001, 1'b0);
      add_row(K_SRAI, 24, 10, 0, 16'h001f, 1'b0);
      add_row(K_SLLI, 25, 1, 0, 16'h001f, 1'b0);
      add_row(K_ADD, 0, 1, 2, 16'h0000, 1'b0);
      add_row(K_OR, 26, 0, 0, 16'h0000, 1'b0);
      add_row(K_LOAD, 4, 2, 0, 16'h0010, 1'b0);
      add_row(K_MUL, 5, 1, 2, 16'h0000, 1'b0);
      add_row(K_SYS, 0, 0, 0, 16'h0042, 1'b0);
      add_row(K_OR, 27, 4, 0, 16'h0000, 1'b0);
      add_row(K_OR, 28, 5, 0, 16'h0000, 1'b0);

      repeat (4) @(posedge clk);
      arst_n_i <= 1'b1;
      @(negedge clk);
      assert (!busy_o && !wb_valid_o) else report_problem("busy or writeback after reset");
      assert (!except_illegal_o && !except_syscall_o)
         else report_problem("exception output high after reset");

      foreach (rows[i]) begin
         run_row(rows[i]);
      end

      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire
